//--- br_resolve_top.f
+incdir+.
bpu_pkg.sv
br_decode_pkg.sv
br_compare.sv
br_target_gen.sv
br_miss_check.sv
br_resolve_ctrl.sv
br_resolve_top.sv
br_resolve_props.sv
br_resolve_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := br_resolve_tb
FILELIST   := br_resolve_top.f
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- br_resolve_tb.sv
/* Testbench for the branch resolution stage
   Table of branches applied in a loop, each row checked one cycle later */

`timescale 1ns/100ps

module br_resolve_tb
	import bpu_pkg::*, br_decode_pkg::*;
();

	localparam word_t PC_A = 32'h1c00_0010;
	localparam word_t PC_B = 32'h1c00_0014;
	// Conditional offset of 16 bytes, rj r4, rd r5
	localparam logic [25:0] COND_INST = {16'd4, 5'd4, 5'd5};
	localparam word_t T_COND = 32'h1c00_0020;
	localparam word_t F_COND = 32'h1c00_0018;

	typedef struct packed {
		word_t        pc;
		word_t        rj;
		word_t        rd;
		decode_info_t dec;
		bpu_predict_t pred;
		logic         stall;
		logic         csr;
		word_t        csr_target;
		logic         exp_taken;
		word_t        exp_target;
		br_kind_t     exp_kind;
		logic         exp_flush;
	} row_t;

	logic         clk;
	logic         reset_i;
	logic         stall_i;
	logic         csr_flush_i;
	word_t        csr_target_i;
	word_t        pc_i;
	word_t        rj_i;
	word_t        rd_i;
	decode_info_t decode_i;
	bpu_predict_t predict_i;
	bpu_update_t  update_o;
	word_t        pc_link_o;

	row_t rows[$];
	int   errors = 0;
	int   checks = 0;
	int   cycles = 0;
	int   cycle_limit = 0;
	int   prop_fails = 0;

	br_resolve_top dut (
		.clk          (clk),
		.reset_i      (reset_i),
		.stall_i      (stall_i),
		.csr_flush_i  (csr_flush_i),
		.csr_target_i (csr_target_i),
		.pc_i         (pc_i),
		.rj_i         (rj_i),
		.rd_i         (rd_i),
		.decode_i     (decode_i),
		.predict_i    (predict_i),
		.update_o     (update_o),
		.pc_link_o    (pc_link_o)
	);

	bind br_resolve_ctrl br_resolve_props u_props (
		.clk         (clk),
		.reset_i     (reset_i),
		.stall_i     (stall_i),
		.csr_flush_i (csr_flush_i),
		.update_i    (update_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// Row builders
	// ------------------------------------------------------------------

	function automatic decode_info_t dec_of(input logic valid, input branch_type_t bt,
		input cmp_type_t cmp, input logic link, input logic [25:0] inst);
		decode_info_t d;
		d.valid = valid;
		d.branch_type = bt;
		d.cmp_type = cmp;
		d.branch_link = link;
		d.inst25_0 = inst;
		return d;
	endfunction

	function automatic decode_info_t cond_dec(input cmp_type_t cmp);
		return dec_of(1'b1, BRANCH_CONDITION, cmp, 1'b0, COND_INST);
	endfunction

	// History fields differ from row to row
	function automatic bpu_predict_t pred_of(input logic taken, input word_t npc);
		bpu_predict_t p;
		p.taken = taken;
		p.npc = npc[31:2];
		p.lphr = 2'(rows.size());
		p.lphr_index = 8'(rows.size()) ^ 8'h5a;
		return p;
	endfunction

	function automatic logic [25:0] inst16(input logic [15:0] offs, input logic [4:0] rj_idx,
		input logic [4:0] rd_idx);
		return {offs, rj_idx, rd_idx};
	endfunction

	// 26-bit offset keeps its upper ten bits at the bottom
	function automatic logic [25:0] inst26(input logic [25:0] offs);
		return {offs[15:0], offs[25:16]};
	endfunction

	function automatic logic cmp_expect(input cmp_type_t c, input word_t a, input word_t b);
		logic eq;
		logic lt_u;
		logic lt_s;
		eq = (a == b);
		lt_u = (a < b);
		// Flipping the sign bits maps signed order onto unsigned order
		lt_s = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
		case (c)
			CMP_EQL: return eq;
			CMP_NEQ: return !eq;
			CMP_LSS: return lt_s;
			CMP_GER: return !lt_s && !eq;
			CMP_LEQ: return lt_s || eq;
			CMP_GEQ: return !lt_s;
			CMP_LTU: return lt_u;
			default: return !lt_u;
		endcase
	endfunction

	task automatic add_row(input word_t pc, input word_t rj, input word_t rd,
		input decode_info_t dec, input bpu_predict_t pred, input logic stall, input logic csr,
		input word_t csr_target, input logic taken, input word_t target, input br_kind_t kind,
		input logic flush);
		row_t r;
		r.pc = pc;
		r.rj = rj;
		r.rd = rd;
		r.dec = dec;
		r.pred = pred;
		r.stall = stall;
		r.csr = csr;
		r.csr_target = csr_target;
		r.exp_taken = taken;
		r.exp_target = target;
		r.exp_kind = kind;
		r.exp_flush = flush;
		rows.push_back(r);
	endtask

	// Conditional branch with a correct guess
	task automatic cond_row(input cmp_type_t cmp, input word_t rj, input word_t rd,
		input logic taken);
		add_row(PC_A, rj, rd, cond_dec(cmp), pred_of(taken, taken ? T_COND : F_COND),
			1'b0, 1'b0, '0, taken, taken ? T_COND : F_COND, BR_PC_RELATIVE, 1'b0);
	endtask

	// Jump with a correct guess
	task automatic jump_row(input word_t rj, input branch_type_t bt, input logic link,
		input logic [25:0] inst, input word_t target, input br_kind_t kind);
		add_row(PC_A, rj, '0, dec_of(1'b1, bt, CMP_EQL, link, inst), pred_of(1'b1, target),
			1'b0, 1'b0, '0, 1'b1, target, kind, 1'b0);
	endtask

	task automatic build_table();
		word_t     rj;
		word_t     rd;
		cmp_type_t cmp;
		// Compare kinds at signed and unsigned edges
		cond_row(CMP_EQL, 32'd5, 32'd5, 1'b1);
		cond_row(CMP_NEQ, 32'd5, 32'd5, 1'b0);
		cond_row(CMP_LSS, 32'h8000_0000, 32'd1, 1'b1);
		cond_row(CMP_LTU, 32'h8000_0000, 32'd1, 1'b0);
		cond_row(CMP_GER, 32'h7fff_ffff, 32'h8000_0000, 1'b1);
		cond_row(CMP_GEU, 32'h7fff_ffff, 32'h8000_0000, 1'b0);
		cond_row(CMP_LEQ, 32'hffff_ffff, 32'hffff_ffff, 1'b1);
		cond_row(CMP_GEQ, 32'hffff_ffff, 32'd0, 1'b0);
		cond_row(CMP_LTU, 32'd0, 32'hffff_ffff, 1'b1);
		cond_row(CMP_GEU, 32'h8000_0000, 32'h7fff_ffff, 1'b1);
		// Targets and return stack kinds
		jump_row('0, BRANCH_IMMEDIATE, 1'b0, inst26(26'h3ff_fff8), 32'h1bff_fff0, BR_ABSOLUTE);
		jump_row('0, BRANCH_IMMEDIATE, 1'b1, inst26(26'h000_0100), 32'h1c00_0410, BR_CALL);
		jump_row(32'h2000_0000, BRANCH_INDIRECT, 1'b0, inst16(16'h0010, 5'd5, 5'd1),
			32'h2000_0040, BR_CALL);
		jump_row(32'h1c00_1238, BRANCH_INDIRECT, 1'b0, inst16(16'h0000, 5'd1, 5'd0),
			32'h1c00_1238, BR_RETURN);
		jump_row(32'h3000_0100, BRANCH_INDIRECT, 1'b0, inst16(16'hfffc, 5'd3, 5'd0),
			32'h3000_00f0, BR_ABSOLUTE);
		jump_row(32'h1c00_1238, BRANCH_INDIRECT, 1'b0, inst16(16'h0004, 5'd1, 5'd0),
			32'h1c00_1248, BR_ABSOLUTE);
		jump_row(32'h4000_0000, BRANCH_INDIRECT, 1'b0, inst16(16'h0000, 5'd1, 5'd1),
			32'h4000_0000, BR_CALL);
		// Wrongly taken at pc bit 2 zero, then a miss in the shadow
		add_row(PC_A, 32'd1, 32'd2, cond_dec(CMP_EQL), pred_of(1'b1, T_COND), 1'b0, 1'b0, '0,
			1'b0, 32'h1c00_0014, BR_PC_RELATIVE, 1'b1);
		add_row(PC_A, 32'd2, 32'd2, cond_dec(CMP_EQL), pred_of(1'b0, '0), 1'b0, 1'b0, '0,
			1'b1, T_COND, BR_PC_RELATIVE, 1'b0);
		// Wrongly taken at pc bit 2 one repairs to the fall-through pair
		add_row(PC_B, 32'd1, 32'd1, cond_dec(CMP_NEQ), pred_of(1'b1, 32'h1c00_0100), 1'b0, 1'b0,
			'0, 1'b0, F_COND, BR_PC_RELATIVE, 1'b1);
		cond_row(CMP_EQL, 32'd0, 32'd0, 1'b1);
		// Target miss on a taken jump
		add_row(PC_A, '0, '0, dec_of(1'b1, BRANCH_IMMEDIATE, CMP_EQL, 1'b0, inst26(26'h3ff_fff8)),
			pred_of(1'b1, '0), 1'b0, 1'b0, '0, 1'b1, 32'h1bff_fff0, BR_ABSOLUTE, 1'b1);
		cond_row(CMP_NEQ, 32'd3, 32'd4, 1'b1);
		// Stall and CSR redirect
		add_row(PC_A, 32'd1, 32'd2, cond_dec(CMP_EQL), pred_of(1'b1, T_COND), 1'b1, 1'b0, '0,
			1'b0, 32'h1c00_0014, BR_PC_RELATIVE, 1'b0);
		add_row(PC_A, 32'd7, 32'd7, cond_dec(CMP_EQL), pred_of(1'b1, T_COND), 1'b1, 1'b1,
			32'h1c00_8000, 1'b1, 32'h1c00_8000, BR_PC_RELATIVE, 1'b1);
		cond_row(CMP_GEU, 32'd5, 32'd5, 1'b1);
		add_row(PC_A, '0, '0, dec_of(1'b0, BRANCH_INVALID, CMP_EQL, 1'b0, '0), pred_of(1'b0, '0),
			1'b0, 1'b1, 32'h1c00_9000, 1'b0, 32'h1c00_9000, BR_PC_RELATIVE, 1'b1);
		cond_row(CMP_LTU, 32'd1, 32'd2, 1'b1);
		// Random operands, equal about a quarter of the time
		for (int n = 0; n < 8; n++) begin
			rj = $urandom();
			rd = ($urandom_range(3) == 0) ? rj : $urandom();
			cmp = cmp_type_t'($urandom_range(7));
			cond_row(cmp, rj, rd, cmp_expect(cmp, rj, rd));
		end
	endtask

	// ------------------------------------------------------------------
	// Drive and check
	// ------------------------------------------------------------------

	task automatic drive(input row_t r);
		pc_i = r.pc;
		rj_i = r.rj;
		rd_i = r.rd;
		decode_i = r.dec;
		predict_i = r.pred;
		stall_i = r.stall;
		csr_flush_i = r.csr;
		csr_target_i = r.csr_target;
	endtask

	task automatic value_error(input string name, input word_t got, input word_t exp);
		$display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		errors++;
	endtask

	task automatic check(input row_t r);
		word_t link_exp;
		word_t pc_exp;
		link_exp = r.pc + 32'd4;
		pc_exp = r.pc >> 2;
		assert (update_o.flush == r.exp_flush)
			else value_error("update_o.flush", word_t'(update_o.flush), word_t'(r.exp_flush));
		assert (update_o.br_taken == r.exp_taken)
			else value_error("update_o.br_taken", word_t'(update_o.br_taken),
				word_t'(r.exp_taken));
		assert (update_o.br_target == r.exp_target)
			else value_error("update_o.br_target", update_o.br_target, r.exp_target);
		assert (update_o.br_type == r.exp_kind)
			else value_error("update_o.br_type", word_t'(update_o.br_type), word_t'(r.exp_kind));
		assert (word_t'(update_o.pc) == pc_exp)
			else value_error("update_o.pc", word_t'(update_o.pc), pc_exp);
		assert (update_o.lphr == r.pred.lphr)
			else value_error("update_o.lphr", word_t'(update_o.lphr), word_t'(r.pred.lphr));
		assert (update_o.lphr_index == r.pred.lphr_index)
			else value_error("update_o.lphr_index", word_t'(update_o.lphr_index),
				word_t'(r.pred.lphr_index));
		assert (pc_link_o == link_exp)
			else value_error("pc_link_o", pc_link_o, link_exp);
		checks += 8;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit != 0 && cycles > cycle_limit) begin
			$display("Timeout: the run passed its limit of %0d cycles", cycle_limit);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		reset_i = 1'b1;
		drive('0);
		void'($urandom(50));
		build_table();
		cycle_limit = rows.size() * 4 + 50;
		repeat (8) @(posedge clk);
		#1;
		reset_i = 1'b0;
		foreach (rows[i]) begin
			drive(rows[i]);
			@(posedge clk);
			#1;
			check(rows[i]);
		end
		drive('0);
		prop_fails = dut.u_ctrl.u_props.fail_count;
		$display("Rows: %0d, checks: %0d, errors: %0d, property failures: %0d",
			rows.size(), checks, errors, prop_fails);
		if (errors == 0 && prop_fails == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- br_resolve_props.sv
/* Branch resolution control properties
   Flush behavior around reset, shadow and stall */

`timescale 1ns/100ps

module br_resolve_props
	import bpu_pkg::*;
(
	input logic        clk,
	input logic        reset_i,
	input logic        stall_i,
	input logic        csr_flush_i,
	input bpu_update_t update_i
);

	// Count of failed properties
	int fail_count = 0;

	// Flush register cleared by reset
	flush_after_reset: assert property (@(posedge clk) reset_i |=> !update_i.flush)
		else begin
			fail_count++;
			$error("update flush high in the cycle after reset");
		end

	// Wrong-path instruction behind a miss flush never flushes again
	no_double_miss_flush: assert property (@(posedge clk) disable iff (reset_i)
		(update_i.flush && !$past(csr_flush_i))
		|=> !(update_i.flush && !$past(csr_flush_i)))
		else begin
			fail_count++;
			$error("second misprediction flush right after a misprediction flush");
		end

	// Stalled instruction is not consumed
	no_flush_under_stall: assert property (@(posedge clk) disable iff (reset_i)
		(update_i.flush && $past(stall_i)) |-> $past(csr_flush_i))
		else begin
			fail_count++;
			$error("misprediction flush raised while stalled");
		end

endmodule

//--- br_resolve_top.sv
/* Branch resolution stage
   Direction, target and miss datapath feeding the registered control block */

`timescale 1ns/100ps

module br_resolve_top
	import bpu_pkg::*, br_decode_pkg::*;
(
	input  logic         clk,
	input  logic         reset_i,
	input  logic         stall_i,
	input  logic         csr_flush_i,
	input  word_t        csr_target_i,
	input  word_t        pc_i,
	input  word_t        rj_i,
	input  word_t        rd_i,
	input  decode_info_t decode_i,
	input  bpu_predict_t predict_i,
	output bpu_update_t  update_o,
	output word_t        pc_link_o
);

	logic        taken;
	logic        miss;
	resolve_t    resolve;
	bpu_update_t update_nxt;

	br_compare u_compare (
		.decode_i (decode_i),
		.rj_i     (rj_i),
		.rd_i     (rd_i),
		.taken_o  (taken)
	);

	br_target_gen u_target_gen (
		.decode_i  (decode_i),
		.pc_i      (pc_i),
		.rj_i      (rj_i),
		.taken_i   (taken),
		.resolve_o (resolve)
	);

	br_miss_check u_miss_check (
		.decode_i     (decode_i),
		.resolve_i    (resolve),
		.predict_i    (predict_i),
		.pc_i         (pc_i),
		.csr_flush_i  (csr_flush_i),
		.csr_target_i (csr_target_i),
		.miss_o       (miss),
		.update_o     (update_nxt)
	);

	br_resolve_ctrl u_ctrl (
		.clk         (clk),
		.reset_i     (reset_i),
		.stall_i     (stall_i),
		.csr_flush_i (csr_flush_i),
		.valid_i     (decode_i.valid),
		.miss_i      (miss),
		.update_i    (update_nxt),
		.link_i      (resolve.link),
		.update_o    (update_o),
		.pc_link_o   (pc_link_o)
	);

endmodule

//--- br_resolve_ctrl.sv
/* Branch resolution control
   Gates flushes by valid, stall and shadow, registers update and link */

`timescale 1ns/100ps

module br_resolve_ctrl
	import bpu_pkg::*;
(
	input  logic        clk,
	input  logic        reset_i,
	input  logic        stall_i,
	input  logic        csr_flush_i,
	input  logic        valid_i,
	input  logic        miss_i,
	input  bpu_update_t update_i,
	input  word_t       link_i,
	output bpu_update_t update_o,
	output word_t       pc_link_o
);

	typedef enum logic {
		RUN    = 1'b0,
		SHADOW = 1'b1
	} ctrl_state_t;

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	logic        miss_flush;
	logic        flush_d;
	logic        flush_q;
	bpu_update_t upd_q;

	// --------------------------------------------------------------------
	// Flush decision
	// --------------------------------------------------------------------

	// Instruction right behind a flush is wrong path
	assign miss_flush = valid_i & ~stall_i & miss_i & (state_q == RUN);
	assign flush_d = miss_flush | csr_flush_i;

	always_comb begin
		state_d = state_q;
		if (flush_d)
			state_d = SHADOW;
		else if (state_q == SHADOW && !stall_i)
			state_d = RUN;
	end

	// --------------------------------------------------------------------
	// Registers
	// --------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= RUN;
			flush_q <= 1'b0;
			pc_link_o <= '0;
		end else begin
			state_q <= state_d;
			flush_q <= flush_d;
			pc_link_o <= link_i;
		end
	end

	// Record follows the inputs even under stall
	always_ff @(posedge clk) begin
		upd_q <= update_i;
	end

	always_comb begin
		update_o = upd_q;
		update_o.flush = flush_q;
	end

endmodule

//--- br_miss_check.sv
/* Misprediction check
   Compares guess and outcome, classifies the branch, picks the repair target */

`timescale 1ns/100ps
`include "br_config.svh"

module br_miss_check
	import bpu_pkg::*, br_decode_pkg::*;
(
	input  decode_info_t decode_i,
	input  resolve_t     resolve_i,
	input  bpu_predict_t predict_i,
	input  word_t        pc_i,
	input  logic         csr_flush_i,
	input  word_t        csr_target_i,
	output logic         miss_o,
	output bpu_update_t  update_o
);

	word_t    predict_npc;
	word_pc_t pc_next;
	reg_idx_t rj_index;
	reg_idx_t rd_index;
	logic     target_miss;
	logic     direction_miss;
	logic     false_taken;
	logic     is_indirect;

	assign predict_npc = {predict_i.npc, {`BR_ALIGN_BITS{1'b0}}};
	assign rj_index = decode_i.inst25_0[9:5];
	assign rd_index = decode_i.inst25_0[4:0];
	assign is_indirect = (decode_i.branch_type == BRANCH_INDIRECT);

	// Target only matters if the front end actually jumped
	assign target_miss = (predict_npc != resolve_i.target);
	assign direction_miss = (predict_i.taken != resolve_i.taken);
	assign miss_o = (target_miss & predict_i.taken) | direction_miss;

	// First slot of a pair guessed taken but falls through
	assign false_taken = predict_i.taken & ~resolve_i.taken;
	assign pc_next = pc_i[`BR_XLEN-1:`BR_ALIGN_BITS] + 1'b1;

	always_comb begin
		update_o.flush = 1'b0;
		update_o.br_taken = resolve_i.taken;
		update_o.pc = pc_i[`BR_XLEN-1:`BR_ALIGN_BITS];
		update_o.lphr = predict_i.lphr;
		update_o.lphr_index = predict_i.lphr_index;

		// Repair target, CSR redirect wins
		if (csr_flush_i)
			update_o.br_target = csr_target_i;
		else if (!pc_i[`BR_ALIGN_BITS] && false_taken)
			update_o.br_target = {pc_next, {`BR_ALIGN_BITS{1'b0}}};
		else
			update_o.br_target = resolve_i.target;

		// Return stack class
		if ((is_indirect && rd_index == `BR_RA_INDEX) || decode_i.branch_link)
			update_o.br_type = BR_CALL;
		else if (is_indirect && rj_index == `BR_RA_INDEX && resolve_i.offs16_zero)
			update_o.br_type = BR_RETURN;
		else if (decode_i.branch_type == BRANCH_IMMEDIATE || is_indirect)
			update_o.br_type = BR_ABSOLUTE;
		else
			update_o.br_type = BR_PC_RELATIVE;
	end

endmodule

//--- br_target_gen.sv
/* Branch target generator
   Builds both offset formats and computes target and link addresses */

`timescale 1ns/100ps
`include "br_config.svh"

module br_target_gen
	import bpu_pkg::*, br_decode_pkg::*;
(
	input  decode_info_t decode_i,
	input  word_t        pc_i,
	input  word_t        rj_i,
	input  logic         taken_i,
	output resolve_t     resolve_o
);

	word_t offs_26;
	word_t offs_16;
	word_t fall_thru;
	word_t target;
	logic [`BR_XLEN-`BR_FETCH_BITS-1:0] fetch_next;

	// --------------------------------------------------------------------
	// Offsets
	// --------------------------------------------------------------------

	// 26-bit form keeps its high part in bits 9:0
	assign offs_26 = {{(`BR_XLEN-28){decode_i.inst25_0[9]}},
		decode_i.inst25_0[9:0], decode_i.inst25_0[25:10], 2'b00};

	assign offs_16 = {{(`BR_XLEN-18){decode_i.inst25_0[25]}},
		decode_i.inst25_0[25:10], 2'b00};

	// Next fetch pair, not pc + 4
	assign fetch_next = pc_i[`BR_XLEN-1:`BR_FETCH_BITS] + 1'b1;
	assign fall_thru = {fetch_next, {`BR_FETCH_BITS{1'b0}}};

	// --------------------------------------------------------------------
	// Target select
	// --------------------------------------------------------------------

	always_comb begin
		case (decode_i.branch_type)
			BRANCH_IMMEDIATE: target = pc_i + offs_26;
			BRANCH_INDIRECT:  target = rj_i + offs_16;
			BRANCH_CONDITION: target = taken_i ? (pc_i + offs_16) : fall_thru;
			default:          target = fall_thru;
		endcase
	end

	always_comb begin
		resolve_o.taken = taken_i;
		resolve_o.target = target;
		resolve_o.link = pc_i + word_t'(4);
		// jirl r0, r1, 0 is the return idiom
		resolve_o.offs16_zero = (decode_i.inst25_0[25:10] == 16'd0);
	end

endmodule

//--- br_compare.sv
/* Branch direction unit
   Evaluates the compare type of a conditional branch on rj and rd */

`timescale 1ns/100ps

module br_compare
	import bpu_pkg::*, br_decode_pkg::*;
(
	input  decode_info_t decode_i,
	input  word_t        rj_i,
	input  word_t        rd_i,
	output logic         taken_o
);

	always_comb begin
		taken_o = 1'b0;
		case (decode_i.branch_type)
			BRANCH_CONDITION: begin
				case (decode_i.cmp_type)
					CMP_EQL: taken_o = (rj_i == rd_i);
					CMP_NEQ: taken_o = (rj_i != rd_i);
					CMP_LSS: taken_o = ($signed(rj_i) < $signed(rd_i));
					CMP_GER: taken_o = ($signed(rj_i) > $signed(rd_i));
					CMP_LEQ: taken_o = ($signed(rj_i) <= $signed(rd_i));
					CMP_GEQ: taken_o = ($signed(rj_i) >= $signed(rd_i));
					// Unsigned forms
					CMP_LTU: taken_o = (rj_i < rd_i);
					CMP_GEU: taken_o = (rj_i >= rd_i);
				endcase
			end
			// Jumps always go
			BRANCH_IMMEDIATE,
			BRANCH_INDIRECT: taken_o = 1'b1;
			default: taken_o = 1'b0;
		endcase
	end

endmodule

//--- br_decode_pkg.sv
/* Decoder view of a branch instruction
   Branch and compare encodings, decode record and resolved result */

package br_decode_pkg;

	import bpu_pkg::*;

	// Register file index
	typedef logic [4:0] reg_idx_t;

	typedef enum logic [1:0] {
		BRANCH_INVALID   = 2'd0,
		BRANCH_CONDITION = 2'd1,
		BRANCH_IMMEDIATE = 2'd2,
		BRANCH_INDIRECT  = 2'd3
	} branch_type_t;

	typedef enum logic [2:0] {
		CMP_EQL = 3'd0,
		CMP_NEQ = 3'd1,
		CMP_LSS = 3'd2,
		CMP_GER = 3'd3,
		CMP_LEQ = 3'd4,
		CMP_GEQ = 3'd5,
		CMP_LTU = 3'd6,
		CMP_GEU = 3'd7
	} cmp_type_t;

	typedef struct packed {
		logic         valid;
		branch_type_t branch_type;
		cmp_type_t    cmp_type;
		logic         branch_link;
		logic [25:0]  inst25_0;
	} decode_info_t;

	// Outcome of the datapath
	typedef struct packed {
		logic  taken;
		word_t target;
		word_t link;
		logic  offs16_zero;
	} resolve_t;

endpackage

//--- bpu_pkg.sv
/* Predictor interface types
   Address words, the prediction record and the update record */

package bpu_pkg;

	`include "br_config.svh"

	// Address and data words
	typedef logic [`BR_XLEN-1:0] word_t;
	typedef logic [`BR_XLEN-`BR_ALIGN_BITS-1:0] word_pc_t;

	// Local history fields, opaque here
	typedef logic [1:0] lphr_t;
	typedef logic [7:0] lphr_index_t;

	// Branch kind, used by the return stack
	typedef enum logic [1:0] {
		BR_PC_RELATIVE = 2'd0,
		BR_ABSOLUTE    = 2'd1,
		BR_CALL        = 2'd2,
		BR_RETURN      = 2'd3
	} br_kind_t;

	// Front end guess for the instruction
	typedef struct packed {
		logic        taken;
		word_pc_t    npc;
		lphr_t       lphr;
		lphr_index_t lphr_index;
	} bpu_predict_t;

	// Feedback to the predictor
	typedef struct packed {
		logic        flush;
		logic        br_taken;
		word_pc_t    pc;
		word_t       br_target;
		br_kind_t    br_type;
		lphr_t       lphr;
		lphr_index_t lphr_index;
	} bpu_update_t;

endpackage

//--- br_config.svh
/* Branch resolution configuration macros
   Widths and register indices fixed by the LoongArch 32-bit ISA */

`ifndef BR_CONFIG_SVH
`define BR_CONFIG_SVH

// Data and address width
`define BR_XLEN 32

// Low PC bits dropped in predictor addresses
`define BR_ALIGN_BITS 2

// Fetch pair alignment, two instructions per fetch
`define BR_FETCH_BITS 3

// Return address register r1
`define BR_RA_INDEX 5'd1

`endif
